//--- div_pkg.sv
// shared widths, loop counts, opcode and state enums and the job context for the divide unit
package div_pkg;

    localparam int XLEN = 64;   // datapath width

    typedef logic [XLEN-1:0] bus64_t;

    // loop counter start values, one extra step for the leading dummy bit
    localparam logic [6:0] ITER_64 = 7'd65;
    localparam logic [6:0] ITER_32 = 7'd33;

    // M-extension divide opcodes, word form selected separately
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    // iteration core FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_OP   = 2'b01,    // one quotient bit per cycle
        ST_LAST = 2'b10,    // final compare, no shift
        ST_DONE = 2'b11     // result cycle
    } div_state_e;

    // captured when the core accepts a job, used again at the result cycle
    typedef struct packed {
        div_op_e op;
        logic    word;
        logic    neg_quo;   // quotient gets negated
        logic    neg_rmd;   // remainder gets negated
        logic    div_zero;
        bus64_t  dividend;  // raw operand, returned as remainder on divide by zero
    } div_ctx_t;

endpackage

//--- div_job_if.sv
// job handoff between operand preparation and the iteration core, with the accept reply
interface div_job_if;
    import div_pkg::*;

    logic   request;
    logic   word;
    bus64_t dvnd_mag;   // word jobs arrive in the upper half
    bus64_t dvsr_mag;   // word jobs zero-extended
    logic   accept;     // core takes the job this cycle

    modport prep (
        output request,
        output word,
        output dvnd_mag,
        output dvsr_mag,
        input  accept
    );

    modport core (
        input  request,
        input  word,
        input  dvnd_mag,
        input  dvsr_mag,
        output accept
    );

endinterface

//--- div_operand_prep.sv
// opcode decode and operand magnitudes for the divide unit, registers the job context on accept
module div_operand_prep (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             request_i,
    input  div_pkg::div_op_e op_i,
    input  logic             word_i,
    input  div_pkg::bus64_t  dvnd_i,
    input  div_pkg::bus64_t  dvsr_i,
    div_job_if.prep          job,
    output div_pkg::div_ctx_t ctx_o
);
    import div_pkg::*;

    logic     signed_op;
    logic     dvnd_sign;
    logic     dvsr_sign;
    logic     dvnd_neg;
    logic     dvsr_neg;
    logic     div_zero;
    bus64_t   dvnd_abs;
    bus64_t   dvsr_abs;
    div_ctx_t ctx_d;

    assign signed_op = (op_i == OP_DIV) || (op_i == OP_REM);

    // sign position depends on the operand width
    assign dvnd_sign = word_i ? dvnd_i[31] : dvnd_i[XLEN-1];
    assign dvsr_sign = word_i ? dvsr_i[31] : dvsr_i[XLEN-1];

    assign dvnd_neg = signed_op & dvnd_sign;
    assign dvsr_neg = signed_op & dvsr_sign;

    assign dvnd_abs = dvnd_neg ? (~dvnd_i + 1'b1) : dvnd_i;
    assign dvsr_abs = dvsr_neg ? (~dvsr_i + 1'b1) : dvsr_i;

    assign div_zero = word_i ? ~(|dvsr_i[31:0]) : ~(|dvsr_i);

    assign job.request  = request_i;
    assign job.word     = word_i;
    // word dividend sits high so 32 shifts bring it into the remainder
    assign job.dvnd_mag = word_i ? {dvnd_abs[31:0], 32'b0} : dvnd_abs;
    assign job.dvsr_mag = word_i ? {32'b0, dvsr_abs[31:0]} : dvsr_abs;

    always_comb begin
        ctx_d          = '0;
        ctx_d.op       = op_i;
        ctx_d.word     = word_i;
        ctx_d.neg_quo  = dvnd_neg ^ dvsr_neg;   // truncation toward zero
        ctx_d.neg_rmd  = dvnd_neg;              // remainder follows the dividend
        ctx_d.div_zero = div_zero;
        ctx_d.dividend = dvnd_i;
    end

    // held for the whole operation, read by the result stage
    always_ff @(posedge clk_i) begin
        if (job.accept) begin
            ctx_o <= ctx_d;
        end
    end

    // context must stay put while a job is in flight
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $changed(ctx_o) |-> $past(job.accept))
        else $error("context changed without an accepted job");

endmodule

//--- div_iter_core.sv
// restoring shift-subtract divider core, one quotient bit per cycle with kill support
module div_iter_core (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_i,
    div_job_if.core         job,
    output div_pkg::bus64_t quo_mag_o,
    output div_pkg::bus64_t rmd_mag_o,
    output logic            busy_o,
    output logic            fin_o
);
    import div_pkg::*;

    div_state_e state_q;
    div_state_e state_d;
    logic [6:0] cnt_q;
    logic [6:0] cnt_d;
    bus64_t     rh_q;       // partial remainder
    bus64_t     rh_d;
    bus64_t     rl_q;       // dividend bits out, quotient bits in
    bus64_t     rl_d;
    bus64_t     dvsr_q;
    bus64_t     dvsr_d;
    bus64_t     rh_tmp;
    logic       q_bit;

    // compare and conditional subtract
    always_comb begin
        if (rh_q >= dvsr_q) begin
            rh_tmp = rh_q - dvsr_q;
            q_bit  = 1'b1;
        end else begin
            rh_tmp = rh_q;
            q_bit  = 1'b0;
        end
    end

    assign job.accept = job.request & ~kill_i & (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        rh_d    = rh_q;
        rl_d    = rl_q;
        dvsr_d  = dvsr_q;
        case (state_q)
            ST_IDLE: begin
                if (job.accept) begin
                    rh_d    = '0;
                    rl_d    = job.dvnd_mag;
                    dvsr_d  = job.dvsr_mag;
                    cnt_d   = job.word ? ITER_32 : ITER_64;
                    state_d = ST_OP;
                end
            end
            ST_OP: begin
                if (kill_i) begin
                    state_d = ST_IDLE;
                end else begin
                    // rh_tmp[63] is still clear here, the partial value has under 64 bits
                    rl_d  = {rl_q[XLEN-2:0], q_bit};
                    rh_d  = {rh_tmp[XLEN-2:0], rl_q[XLEN-1]};
                    cnt_d = cnt_q - 1'b1;
                    if (cnt_d == 7'd1) begin
                        state_d = ST_LAST;
                    end
                end
            end
            ST_LAST: begin
                if (kill_i) begin
                    state_d = ST_IDLE;
                end else begin
                    rl_d    = {rl_q[XLEN-2:0], q_bit};
                    rh_d    = rh_tmp;   // final remainder, no shift
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // datapath registers
    always_ff @(posedge clk_i) begin
        rh_q   <= rh_d;
        rl_q   <= rl_d;
        dvsr_q <= dvsr_d;
    end

    assign busy_o    = (state_q == ST_OP) || (state_q == ST_LAST);
    assign fin_o     = (state_q == ST_DONE) & ~kill_i;     // flush drops the result too
    assign quo_mag_o = rl_q;
    assign rmd_mag_o = rh_q;

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(fin_o && busy_o))
        else $error("fin and busy high together");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        fin_o |=> !fin_o)
        else $error("fin longer than one cycle");

    // the loop shift drops the top remainder bit
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == ST_OP) |-> !rh_tmp[XLEN-1])
        else $error("partial remainder lost its top bit in the shift");

endmodule

//--- div_result_fix.sv
// sign correction, divide-by-zero substitution and result select for the divide unit
module div_result_fix (
    input  logic              fin_i,
    input  div_pkg::div_ctx_t ctx_i,
    input  div_pkg::bus64_t   quo_mag_i,
    input  div_pkg::bus64_t   rmd_mag_i,
    output div_pkg::bus64_t   result_o,
    output logic              done_o
);
    import div_pkg::*;

    bus64_t quo_fix;
    bus64_t rmd_fix;
    bus64_t pick;
    bus64_t res;

    always_comb begin
        quo_fix = ctx_i.neg_quo ? (~quo_mag_i + 1'b1) : quo_mag_i;
        rmd_fix = ctx_i.neg_rmd ? (~rmd_mag_i + 1'b1) : rmd_mag_i;
        if (ctx_i.div_zero) begin
            quo_fix = '1;               // all ones, also after word extension
            rmd_fix = ctx_i.dividend;
        end
    end

    // signed overflow needs nothing here, the magnitude already equals the dividend
    always_comb begin
        case (ctx_i.op)
            OP_DIV,
            OP_DIVU: pick = quo_fix;
            OP_REM,
            OP_REMU: pick = rmd_fix;
            default: pick = quo_fix;
        endcase
    end

    // word results sign-extended from bit 31, also for the unsigned forms
    assign res = ctx_i.word ? {{(XLEN-32){pick[31]}}, pick[31:0]} : pick;

    assign result_o = fin_i ? res : '0;     // zero outside the result cycle
    assign done_o   = fin_i;

endmodule

//--- div_unit_top.sv
// top level of the integer divide unit, plain ports for the execution stage
module div_unit_top (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             kill_i,
    input  logic             request_i,
    input  div_pkg::div_op_e op_i,
    input  logic             word_i,
    input  div_pkg::bus64_t  dvnd_i,    // rs1
    input  div_pkg::bus64_t  dvsr_i,    // rs2
    output div_pkg::bus64_t  result_o,
    output logic             busy_o,
    output logic             done_o
);
    import div_pkg::*;

    div_ctx_t ctx;
    bus64_t   quo_mag;
    bus64_t   rmd_mag;
    logic     fin;

    div_job_if job ();

    div_operand_prep u_prep (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .request_i (request_i),
        .op_i      (op_i),
        .word_i    (word_i),
        .dvnd_i    (dvnd_i),
        .dvsr_i    (dvsr_i),
        .job       (job.prep),
        .ctx_o     (ctx)
    );

    div_iter_core u_core (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .kill_i    (kill_i),
        .job       (job.core),
        .quo_mag_o (quo_mag),
        .rmd_mag_o (rmd_mag),
        .busy_o    (busy_o),
        .fin_o     (fin)
    );

    div_result_fix u_fix (
        .fin_i     (fin),
        .ctx_i     (ctx),
        .quo_mag_i (quo_mag),
        .rmd_mag_i (rmd_mag),
        .result_o  (result_o),
        .done_o    (done_o)
    );

endmodule

//--- tb_div_vectors.svh
// directed stimulus rows for the divide unit testbench, included inside tb_div_unit
`ifndef TB_DIV_VECTORS_SVH
`define TB_DIV_VECTORS_SVH

// columns: opcode, word form, dividend, divisor, expected result
function automatic void fill_table();
    // 64-bit, all four sign combinations
    add_row(OP_DIV,  1'b0, 64'd100,                 64'd7,                 64'd14);
    add_row(OP_REM,  1'b0, 64'd100,                 64'd7,                 64'd2);
    add_row(OP_DIV,  1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7,                 64'hFFFF_FFFF_FFFF_FFF2);
    add_row(OP_REM,  1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7,                 64'hFFFF_FFFF_FFFF_FFFE);
    add_row(OP_DIV,  1'b0, 64'd100,                 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF2);
    add_row(OP_REM,  1'b0, 64'd100,                 64'hFFFF_FFFF_FFFF_FFF9, 64'd2);
    add_row(OP_DIV,  1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 64'd14);
    add_row(OP_REM,  1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE);
    add_row(OP_DIV,  1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 64'd2,                 64'h3FFF_FFFF_FFFF_FFFF);
    add_row(OP_REM,  1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 64'd2,                 64'd1);
    add_row(OP_DIV,  1'b0, 64'd5,                   64'd10,                64'd0);
    add_row(OP_REM,  1'b0, 64'd5,                   64'd10,                64'd5);
    // unsigned 64-bit, top bits set
    add_row(OP_DIVU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h10,                64'h0FFF_FFFF_FFFF_FFFF);
    add_row(OP_REMU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h10,                64'hF);
    add_row(OP_DIVU, 1'b0, 64'h8000_0000_0000_0000, 64'd3,                 64'h2AAA_AAAA_AAAA_AAAA);
    add_row(OP_REMU, 1'b0, 64'h8000_0000_0000_0000, 64'd3,                 64'd2);
    // divide by zero and signed overflow
    add_row(OP_DIV,  1'b0, 64'h123,                 64'd0,                 64'hFFFF_FFFF_FFFF_FFFF);
    add_row(OP_DIVU, 1'b0, 64'h123,                 64'd0,                 64'hFFFF_FFFF_FFFF_FFFF);
    add_row(OP_REM,  1'b0, 64'h123,                 64'd0,                 64'h123);
    add_row(OP_REMU, 1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd0,                 64'hFFFF_FFFF_FFFF_FF9C);
    add_row(OP_DIV,  1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
    add_row(OP_REM,  1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0);
    // word forms, upper operand halves are junk
    add_row(OP_DIV,  1'b1, 64'h1234_5678_FFFF_FF9C, 64'hABCD_EF00_0000_0007, 64'hFFFF_FFFF_FFFF_FFF2);
    add_row(OP_REM,  1'b1, 64'h1234_5678_FFFF_FF9C, 64'hABCD_EF00_0000_0007, 64'hFFFF_FFFF_FFFF_FFFE);
    add_row(OP_DIV,  1'b1, 64'd7,                   64'h0000_0000_FFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFFE);
    add_row(OP_REM,  1'b1, 64'd7,                   64'h0000_0000_FFFF_FFFD, 64'd1);
    add_row(OP_DIVU, 1'b1, 64'h0000_0000_FFFF_FFFF, 64'h0000_0005_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF);
    add_row(OP_REMU, 1'b1, 64'h0000_0000_FFFF_FFFF, 64'h10,                64'hF);
    add_row(OP_REMU, 1'b1, 64'h0000_0000_8000_0001, 64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_8000_0001);
    add_row(OP_DIVU, 1'b1, 64'd1000000,             64'd1000,              64'd1000);
    add_row(OP_DIV,  1'b1, 64'h0000_0000_8000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
    add_row(OP_REM,  1'b1, 64'h0000_0000_8000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0);
    add_row(OP_DIV,  1'b1, 64'd5,                   64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
    add_row(OP_REMU, 1'b1, 64'h0000_0000_8765_4321, 64'd0,                 64'hFFFF_FFFF_8765_4321);
    add_row(OP_REM,  1'b1, 64'h1111_1111_0000_0042, 64'd0,                 64'h42);
endfunction

`endif

//--- tb_div_unit.sv
// self-checking testbench for the divide unit, top module tb_div_unit, built from sources.f
module tb_div_unit;
    import div_pkg::*;

    localparam int NUM_RAND = 40;

    logic    clk;
    logic    rstn;
    logic    kill;
    logic    request;
    div_op_e op;
    logic    word;
    bus64_t  dvnd;
    bus64_t  dvsr;
    bus64_t  result;
    logic    busy;
    logic    done;

    div_op_e tab_op[$];
    logic    tab_word[$];
    bus64_t  tab_dvnd[$];
    bus64_t  tab_dvsr[$];
    bus64_t  tab_exp[$];

    int seed = 66407;
    int cycles = 0;
    int limit = 1000;
    int test_num = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    bit test_err;

    div_unit_top UUT (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .kill_i    (kill),
        .request_i (request),
        .op_i      (op),
        .word_i    (word),
        .dvnd_i    (dvnd),
        .dvsr_i    (dvsr),
        .result_o  (result),
        .busy_o    (busy),
        .done_o    (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("run stopped: %0d cycles passed without the tests finishing", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic void add_row(input div_op_e o, input logic w, input bus64_t a,
                                    input bus64_t b, input bus64_t e);
        tab_op.push_back(o);
        tab_word.push_back(w);
        tab_dvnd.push_back(a);
        tab_dvsr.push_back(b);
        tab_exp.push_back(e);
    endfunction

    `include "tb_div_vectors.svh"

    // M-extension rules, zero divisor and overflow first
    function automatic bus64_t riscv_div(input div_op_e o, input logic w, input bus64_t a,
                                         input bus64_t b);
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic signed [31:0] wq;
        logic signed [31:0] wr;
        logic               is_signed;
        bus64_t             q;
        bus64_t             r;
        is_signed = (o == OP_DIV) || (o == OP_REM);
        if (!w) begin
            if (b == '0) begin
                q = '1;
                r = a;
            end else if (is_signed && a == {1'b1, 63'b0} && b == '1) begin
                q = a;
                r = '0;
            end else if (is_signed) begin
                sq = $signed(a) / $signed(b);
                sr = $signed(a) % $signed(b);
                q  = sq;
                r  = sr;
            end else begin
                q = a / b;
                r = a % b;
            end
        end else begin
            if (b[31:0] == '0) begin
                wq = '1;
                wr = a[31:0];
            end else if (is_signed && a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
                wq = a[31:0];
                wr = '0;
            end else if (is_signed) begin
                wq = $signed(a[31:0]) / $signed(b[31:0]);
                wr = $signed(a[31:0]) % $signed(b[31:0]);
            end else begin
                wq = a[31:0] / b[31:0];
                wr = a[31:0] % b[31:0];
            end
            q = {{32{wq[31]}}, wq};     // word results sign-extended
            r = {{32{wr[31]}}, wr};
        end
        return (o == OP_DIV || o == OP_DIVU) ? q : r;
    endfunction

    task automatic check_val(input string what, input bus64_t got, input bus64_t exp);
        assert (got === exp) else begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            test_err = 1'b1;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("error at %0t: %s", $time, what);
            test_err = 1'b1;
        end
    endtask

    task automatic close_test(input string name);
        test_num++;
        if (test_err) begin
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        $display("test %0d %s: %s", test_num, name, test_err ? "FAIL" : "ok");
        test_err = 1'b0;
    endtask

    // request for one cycle, then scramble inputs so a lost context shows up
    task automatic start_op(input div_op_e o, input logic w, input bus64_t a, input bus64_t b);
        @(negedge clk);
        request = 1'b1;
        op      = o;
        word    = w;
        dvnd    = a;
        dvsr    = b;
        @(negedge clk);
        request = 1'b0;
        op      = div_op_e'(o ^ 2'b01);
        word    = ~w;
        dvnd    = ~a;
        dvsr    = b + 64'd3;
    endtask

    task automatic run_op(input div_op_e o, input logic w, input bus64_t a, input bus64_t b,
                          input bus64_t exp, input int poke, input string name);
        int lat;
        int k;
        lat = w ? 34 : 66;
        start_op(o, w, a, b);
        k = 1;      // first cycle after the accepting edge
        while (!done && k <= lat + 4) begin
            check_true(busy, "busy low before done");
            check_val("result before done", result, '0);
            request = (k == poke);      // must be ignored while busy
            @(negedge clk);
            k++;
        end
        request = 1'b0;
        check_true(done, "done never came");
        assert (k == lat) else begin
            $display("error at %0t: done after %0d cycles, expected %0d", $time, k, lat);
            test_err = 1'b1;
        end
        check_true(!busy, "busy high together with done");
        check_val("result", result, exp);
        close_test(name);
    endtask

    task automatic kill_op(input div_op_e o, input logic w, input bus64_t a, input bus64_t b,
                           input int at, input string name);
        start_op(o, w, a, b);
        repeat (at - 1) @(negedge clk);
        check_true(busy, "busy low before the kill");
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
        check_true(!busy, "busy still high after kill");
        repeat (70) begin
            check_true(!done, "done after a killed operation");
            @(negedge clk);
        end
        close_test(name);
    endtask

    initial begin
        logic [31:0] r;
        div_op_e     ro;
        logic        rw;
        bus64_t      ra;
        bus64_t      rb;
        rstn     = 1'b0;
        kill     = 1'b0;
        request  = 1'b0;
        op       = OP_DIV;
        word     = 1'b0;
        dvnd     = '0;
        dvsr     = '0;
        test_err = 1'b0;
        fill_table();
        limit = (tab_op.size() + NUM_RAND + 8) * 70 + 500;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        check_true(!busy && !done, "busy or done high after reset");
        close_test("reset state");

        foreach (tab_op[i]) begin
            run_op(tab_op[i], tab_word[i], tab_dvnd[i], tab_dvsr[i], tab_exp[i], 0,
                   $sformatf("vector %0d", i));
        end

        run_op(OP_DIVU, 1'b0, 64'd1000, 64'd7, 64'd142, 12, "request while busy");
        run_op(OP_REM, 1'b1, 64'd1000, 64'd7, 64'd6, 20, "word request while busy");

        for (int n = 0; n < NUM_RAND; n++) begin
            r  = $random(seed);
            ro = div_op_e'(r[1:0]);
            rw = r[2];
            ra = {$random(seed), $random(seed)};
            rb = {$random(seed), $random(seed)};
            if (r[5:3] == 3'd0) begin
                rb = '0;
            end else if (r[5:3] < 3'd4) begin
                rb = rb >> r[11:6];     // short divisors, long quotients
            end
            run_op(ro, rw, ra, rb, riscv_div(ro, rw, ra, rb), n % 5 + 3,
                   $sformatf("random %0d", n));
        end

        kill_op(OP_DIV, 1'b0, 64'd12345, 64'd17, 30, "kill mid loop");
        run_op(OP_DIV, 1'b0, 64'd12345, 64'd17, 64'd726, 0, "after kill");
        kill_op(OP_REM, 1'b1, 64'd99, 64'd5, 33, "kill in last word cycle");
        run_op(OP_REM, 1'b1, 64'd99, 64'd5, 64'd4, 0, "after word kill");

        $display("tests %0d, passed %0d, failed %0d", test_num, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
div_pkg.sv
div_job_if.sv
div_operand_prep.sv
div_iter_core.sv
div_result_fix.sv
div_unit_top.sv
tb_div_unit.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_div_unit -f sources.f \
    -o tb_div_unit > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_div_unit > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1
